// ==== build.f ====
src/flags_rf_pkg.sv
src/flags_tile.sv
src/flags_tile_array.sv
src/flags_clear_seq.sv
src/flags_forward.sv
src/flags_rf.sv
test/clk_gen.sv
test/flags_rf_sva.sv
test/flags_rf_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the flags register file testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module flags_rf_tb -o sim_flags_rf

# The simulation status is judged from the log below
./obj_dir/sim_flags_rf > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== test/flags_rf_tb.sv ====
// Testbench for the flags register file with random stimulus and a reference model
`timescale 1ns/1ps

module flags_rf_tb;

  import flags_rf_pkg::*;

  localparam int ENTRIES      = 2 ** ADDR_W;
  localparam int CLEAR_CYCLES = ENTRIES / (2 ** TILE_BITS);
  localparam int RAND_CYCLES  = 200;
  localparam int TEST_CYCLES  = (CLEAR_CYCLES + 4) + 4 * (ENTRIES + 1) + 4 * RAND_CYCLES
                                + 2 + 3 * (NUM_WR + 1);
  localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

  logic                          clk;
  logic                          rst;
  logic [NUM_WR-1:0]             wr_en;
  logic [NUM_WR-1:0][ADDR_W-1:0] wr_addr;
  flag_t [NUM_WR-1:0]            wr_flags;
  logic                          alloc_en;
  logic [ADDR_W-1:0]             alloc_addr;
  logic [ADDR_W-1:0]             rd_addr;
  logic [ADDR_W-1:0]             ret_addr;
  entry_t                        rd_data;
  logic [NUM_WR:0]               rd_fwd;
  flag_t                         ret_flags;
  logic                          clear_busy;

  // Next cycle's stimulus that run_cycle copies onto the DUT inputs
  logic [NUM_WR-1:0]             s_wr_en;
  logic [NUM_WR-1:0][ADDR_W-1:0] s_wr_addr;
  flag_t [NUM_WR-1:0]            s_wr_flags;
  logic                          s_alloc_en;
  logic [ADDR_W-1:0]             s_alloc_addr;
  logic [ADDR_W-1:0]             s_rd_addr;
  logic [ADDR_W-1:0]             s_ret_addr;

  entry_t            model_mem [ENTRIES];
  logic [ADDR_W-1:0] prev_rd_addr;
  logic [ADDR_W-1:0] prev_ret_addr;
  integer            seed;
  int                checks;
  int                errors;
  int                tests;
  int                check_mark;
  int                error_mark;
  int                cycle_count;

  clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  flags_rf DUT (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_flags   (wr_flags),
    .alloc_en   (alloc_en),
    .alloc_addr (alloc_addr),
    .rd_addr    (rd_addr),
    .ret_addr   (ret_addr),
    .rd_data    (rd_data),
    .rd_fwd     (rd_fwd),
    .ret_flags  (ret_flags),
    .clear_busy (clear_busy)
  );

  bind flags_rf flags_rf_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .rd_fwd     (rd_fwd),
    .clear_busy (clear_busy)
  );

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected)
    begin
      errors++;
      $display("error at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  // Allocate ahead of the highest enabled write port
  function automatic void expected_read(input logic [ADDR_W-1:0] a, input bit gate0,
                                        output entry_t data, output logic [NUM_WR:0] fwd);
    bit found;
    found = 1'b0;
    data  = model_mem[a];
    fwd   = '0;
    if (s_alloc_en && (s_alloc_addr == a))
    begin
      data        = PENDING_ENTRY;
      fwd[NUM_WR] = 1'b1;
      found       = 1'b1;
    end
    for (int i = NUM_WR - 1; i >= 0; i--)
    begin
      if (!found && s_wr_en[i] && !(i == 0 && gate0) && (s_wr_addr[i] == a))
      begin
        data   = '{pending: 1'b0, flags: s_wr_flags[i]};
        fwd[i] = 1'b1;
        found  = 1'b1;
      end
    end
  endfunction

  task automatic commit_model(input bit gate0);
    for (int i = 0; i < NUM_WR; i++)
    begin
      if (s_wr_en[i] && !(i == 0 && gate0))
      begin
        model_mem[s_wr_addr[i]] = '{pending: 1'b0, flags: s_wr_flags[i]};
      end
    end
    if (s_alloc_en)
    begin
      model_mem[s_alloc_addr] = PENDING_ENTRY;
    end
  endtask

  // Drive at the rising edge and check at the falling edge
  task automatic run_cycle(input bit check_en, input bit gate0);
    entry_t          exp_data;
    logic [NUM_WR:0] exp_fwd;
    @(posedge clk);
    wr_en      <= s_wr_en;
    wr_addr    <= s_wr_addr;
    wr_flags   <= s_wr_flags;
    alloc_en   <= s_alloc_en;
    alloc_addr <= s_alloc_addr;
    rd_addr    <= s_rd_addr;
    ret_addr   <= s_ret_addr;
    @(negedge clk);
    if (check_en)
    begin
      expected_read(prev_rd_addr, gate0, exp_data, exp_fwd);
      check_value("rd_data", exp_data, rd_data);
      check_value("rd_fwd", exp_fwd, rd_fwd);
      check_value("ret_flags", model_mem[prev_ret_addr].flags, ret_flags);
    end
    commit_model(gate0);
    prev_rd_addr  = s_rd_addr;
    prev_ret_addr = s_ret_addr;
  endtask

  task automatic set_idle();
    s_wr_en    = '0;
    s_alloc_en = 1'b0;
  endtask

  task automatic pick_random(input int mask, input bit with_alloc);
    for (int i = 0; i < NUM_WR; i++)
    begin
      s_wr_en[i]    = 1'($random(seed));
      s_wr_addr[i]  = ADDR_W'($random(seed) & mask);
      s_wr_flags[i] = FLAG_W'($random(seed));
    end
    s_alloc_en   = with_alloc && (($random(seed) & 3) == 0);
    s_alloc_addr = ADDR_W'($random(seed) & mask);
    s_rd_addr    = ADDR_W'($random(seed) & mask);
    s_ret_addr   = ADDR_W'($random(seed) & mask);
  endtask

  // Reads every entry on both ports with retire in reverse order
  task automatic sweep_reads();
    set_idle();
    for (int a = 0; a <= ENTRIES; a++)
    begin
      s_rd_addr  = ADDR_W'(a);
      s_ret_addr = ADDR_W'(ENTRIES - 1 - a);
      run_cycle(1'b1, 1'b0);
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %0d %s: %0d checks, %0d errors", tests, name,
             checks - check_mark, errors - error_mark);
    check_mark = checks;
    error_mark = errors;
  endtask

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial
  begin
    logic [ADDR_W-1:0] a;
    seed          = 86800;
    checks        = 0;
    errors        = 0;
    tests         = 0;
    check_mark    = 0;
    error_mark    = 0;
    cycle_count   = 0;
    wr_en         = '0;
    wr_addr       = '0;
    wr_flags      = '0;
    alloc_en      = 1'b0;
    alloc_addr    = '0;
    rd_addr       = '0;
    ret_addr      = '0;
    s_wr_addr     = '0;
    s_wr_flags    = '0;
    s_alloc_addr  = '0;
    s_rd_addr     = '0;
    s_ret_addr    = '0;
    prev_rd_addr  = '0;
    prev_ret_addr = '0;
    set_idle();
    for (int i = 0; i < ENTRIES; i++)
    begin
      model_mem[i] = '0; // Every entry zeroed by the clear
    end

    @(negedge clk);
    while (rst)
    begin
      @(negedge clk);
    end

    // Port 0 writes that land on row 0 after its clear are all dropped
    for (int n = 1; n <= CLEAR_CYCLES + 4; n++)
    begin
      set_idle();
      if (n < CLEAR_CYCLES)
      begin
        s_wr_en[0]    = 1'b1;
        s_wr_addr[0]  = ADDR_W'($random(seed) & 3);
        s_wr_flags[0] = FLAG_W'($random(seed)) | 1;
      end
      run_cycle(1'b0, n < CLEAR_CYCLES);
      check_value("clear_busy", n < CLEAR_CYCLES, clear_busy);
      check_value("rd_fwd", 0, rd_fwd);
    end
    sweep_reads();
    finish_test("clear with port 0 blocked");

    for (int n = 0; n < RAND_CYCLES; n++)
    begin
      pick_random((n % 2) ? 'h07 : 'h3f, 1'b0); // Narrow range forces port conflicts
      run_cycle(1'b1, 1'b0);
    end
    sweep_reads();
    finish_test("write then read");

    a = ADDR_W'($random(seed));
    set_idle();
    s_wr_en[NUM_WR-1]    = 1'b1;
    s_wr_addr[NUM_WR-1]  = a;
    s_wr_flags[NUM_WR-1] = '0;
    s_alloc_en           = 1'b1;
    s_alloc_addr         = a;
    s_rd_addr            = a;
    s_ret_addr           = a;
    run_cycle(1'b1, 1'b0);
    set_idle();
    run_cycle(1'b1, 1'b0);
    check_value("rd_data after allocate", PENDING_ENTRY, rd_data);
    check_value("ret_flags after allocate", {FLAG_W{1'b1}}, ret_flags);
    for (int n = 0; n < RAND_CYCLES; n++)
    begin
      pick_random((n % 2) ? 'h07 : 'h3f, 1'b1);
      run_cycle(1'b1, 1'b0);
    end
    sweep_reads();
    finish_test("allocate");

    // Port index NUM_WR stands for the allocate port
    for (int p = 0; p <= NUM_WR; p++)
    begin
      a = ADDR_W'($random(seed));
      set_idle();
      s_rd_addr = a;
      run_cycle(1'b1, 1'b0);
      if (p == NUM_WR)
      begin
        s_alloc_en   = 1'b1;
        s_alloc_addr = a;
      end
      else
      begin
        s_wr_en[p]    = 1'b1;
        s_wr_addr[p]  = a;
        s_wr_flags[p] = FLAG_W'($random(seed));
      end
      run_cycle(1'b1, 1'b0);
      check_value("rd_fwd source", 32'(1) << p, rd_fwd);
      set_idle();
      run_cycle(1'b1, 1'b0);
      check_value("rd_fwd without write", 0, rd_fwd);
    end
    for (int n = 0; n < RAND_CYCLES; n++)
    begin
      pick_random('h03, 1'b1);
      run_cycle(1'b1, 1'b0);
    end
    finish_test("forwarding");

    for (int n = 0; n < RAND_CYCLES; n++)
    begin
      pick_random('h3f, 1'b1);
      run_cycle(1'b1, 1'b0);
    end
    sweep_reads();
    finish_test("retire read");

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
    begin
      $display("*** TEST PASSED ***");
    end
    else
    begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== test/flags_rf_sva.sv ====
// Concurrent assertions on the flags register file outputs
`timescale 1ns/1ps

module flags_rf_sva (
  input logic                          clk,
  input logic                          rst,
  input logic [flags_rf_pkg::NUM_WR:0] rd_fwd,
  input logic                          clear_busy
);

  logic busy_done_q; // Clear has finished once

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy_done_q <= 1'b0;
    end
    else if (!clear_busy)
    begin
      busy_done_q <= 1'b1;
    end
  end

  a_fwd_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(rd_fwd))
    else $error("rd_fwd names more than one forwarding source");

  a_busy_stays_low: assert property (@(posedge clk) disable iff (rst) busy_done_q |-> !clear_busy)
    else $error("clear_busy rose again after the clear had finished");

  a_fwd_zero_in_reset: assert property (@(posedge clk) rst |-> (rd_fwd == '0))
    else $error("rd_fwd is not zero during reset");

endmodule

// ==== test/clk_gen.sv ====
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module clk_gen #(
  parameter int HALF_PERIOD_NS = 2,
  parameter int RESET_CYCLES   = 3
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD_NS) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== src/flags_rf.sv ====
// Top level flags register file with clear sequencer, tile array and forwarding
`timescale 1ns/1ps

module flags_rf #(
  parameter int ADDR_W    = flags_rf_pkg::ADDR_W,
  parameter int TILE_BITS = flags_rf_pkg::TILE_BITS
) (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [flags_rf_pkg::NUM_WR-1:0]                  wr_en,
  input  logic [flags_rf_pkg::NUM_WR-1:0][ADDR_W-1:0]      wr_addr,
  input  flags_rf_pkg::flag_t [flags_rf_pkg::NUM_WR-1:0]   wr_flags,
  input  logic                                             alloc_en,
  input  logic [ADDR_W-1:0]                                alloc_addr,
  input  logic [ADDR_W-1:0]                                rd_addr,
  input  logic [ADDR_W-1:0]                                ret_addr,
  output flags_rf_pkg::entry_t                             rd_data,
  output logic [flags_rf_pkg::NUM_WR:0]                    rd_fwd,
  output flags_rf_pkg::flag_t                              ret_flags,
  output logic                                             clear_busy
);

  import flags_rf_pkg::*;

  localparam int ROW_W = ADDR_W - TILE_BITS;

  logic              wr0_en_gated;
  logic              clr_en;
  logic [ROW_W-1:0]  clr_row;
  logic [NUM_WR-1:0] wr_en_int;
  entry_t            ram_entry;

  assign wr_en_int = {wr_en[NUM_WR-1:1], wr0_en_gated};

  flags_clear_seq #(
    .ROW_W (ROW_W)
  ) u_clear_seq (
    .clk          (clk),
    .rst          (rst),
    .wr0_en       (wr_en[0]),
    .wr0_en_gated (wr0_en_gated),
    .clr_en       (clr_en),
    .clr_row      (clr_row),
    .clear_busy   (clear_busy)
  );

  flags_tile_array #(
    .ADDR_W    (ADDR_W),
    .TILE_BITS (TILE_BITS)
  ) u_tile_array (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (wr_en_int),
    .wr_addr    (wr_addr),
    .wr_flags   (wr_flags),
    .alloc_en   (alloc_en),
    .alloc_addr (alloc_addr),
    .clr_en     (clr_en),
    .clr_row    (clr_row),
    .rd_addr    (rd_addr),
    .ret_addr   (ret_addr),
    .rd_entry   (ram_entry),
    .ret_flags  (ret_flags)
  );

  flags_forward #(
    .ADDR_W (ADDR_W)
  ) u_forward (
    .clk        (clk),
    .rst        (rst),
    .rd_addr    (rd_addr),
    .ram_entry  (ram_entry),
    .wr_en      (wr_en_int),
    .wr_addr    (wr_addr),
    .wr_flags   (wr_flags),
    .alloc_en   (alloc_en),
    .alloc_addr (alloc_addr),
    .rd_data    (rd_data),
    .rd_fwd     (rd_fwd)
  );

endmodule

// ==== src/flags_forward.sv ====
// Zero-cycle forwarding of same-cycle writes and allocates onto the read data
`timescale 1ns/1ps

module flags_forward #(
  parameter int ADDR_W = flags_rf_pkg::ADDR_W
) (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [ADDR_W-1:0]                                rd_addr,
  input  flags_rf_pkg::entry_t                             ram_entry,
  input  logic [flags_rf_pkg::NUM_WR-1:0]                  wr_en,
  input  logic [flags_rf_pkg::NUM_WR-1:0][ADDR_W-1:0]      wr_addr,
  input  flags_rf_pkg::flag_t [flags_rf_pkg::NUM_WR-1:0]   wr_flags,
  input  logic                                             alloc_en,
  input  logic [ADDR_W-1:0]                                alloc_addr,
  output flags_rf_pkg::entry_t                             rd_data,
  output logic [flags_rf_pkg::NUM_WR:0]                    rd_fwd
);

  import flags_rf_pkg::*;

  logic [ADDR_W-1:0] rd_addr_q;

  // Same address the tiles hold this cycle
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_addr_q <= '0;
    end
    else
    begin
      rd_addr_q <= rd_addr;
    end
  end

  // Port 0 enable arrives already gated by the clear sequencer
  always_comb
  begin
    rd_data = ram_entry;
    rd_fwd  = '0;
    for (int i = 0; i < NUM_WR; i++)
    begin
      if (wr_en[i] && (wr_addr[i] == rd_addr_q))
      begin
        rd_data   = '{pending: 1'b0, flags: wr_flags[i]}; // Higher port overrides
        rd_fwd    = '0;
        rd_fwd[i] = 1'b1;
      end
    end
    if (alloc_en && (alloc_addr == rd_addr_q))
    begin
      rd_data        = PENDING_ENTRY;
      rd_fwd         = '0;
      rd_fwd[NUM_WR] = 1'b1; // Allocate is the top bit
    end
  end

endmodule

// ==== src/flags_clear_seq.sv ====
// Post-reset clear sequencer that borrows write port 0 while it runs
`timescale 1ns/1ps

module flags_clear_seq #(
  parameter int ROW_W = 4
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr0_en,
  output logic             wr0_en_gated,
  output logic             clr_en,
  output logic [ROW_W-1:0] clr_row,
  output logic             clear_busy
);

  import flags_rf_pkg::*;

  clear_state_e     state_q;
  logic [ROW_W-1:0] row_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= CLEAR_RUN;
      row_q   <= '0;
    end
    else if (state_q == CLEAR_RUN)
    begin
      row_q <= row_q + 1'b1;
      if (row_q == {ROW_W{1'b1}})
      begin
        state_q <= CLEAR_IDLE; // Last row done
      end
    end
  end

  assign clr_en     = (state_q == CLEAR_RUN);
  assign clr_row    = row_q;
  assign clear_busy = clr_en;

  // Outside port 0 is dropped during the clear
  assign wr0_en_gated = wr0_en && !clr_en;

endmodule

// ==== src/flags_tile_array.sv ====
// Tile select decode, array of storage tiles and read output selection
`timescale 1ns/1ps

module flags_tile_array #(
  parameter int ADDR_W    = flags_rf_pkg::ADDR_W,
  parameter int TILE_BITS = flags_rf_pkg::TILE_BITS
) (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [flags_rf_pkg::NUM_WR-1:0]                  wr_en,
  input  logic [flags_rf_pkg::NUM_WR-1:0][ADDR_W-1:0]      wr_addr,
  input  flags_rf_pkg::flag_t [flags_rf_pkg::NUM_WR-1:0]   wr_flags,
  input  logic                                             alloc_en,
  input  logic [ADDR_W-1:0]                                alloc_addr,
  input  logic                                             clr_en,
  input  logic [ADDR_W-TILE_BITS-1:0]                      clr_row,
  input  logic [ADDR_W-1:0]                                rd_addr,
  input  logic [ADDR_W-1:0]                                ret_addr,
  output flags_rf_pkg::entry_t                             rd_entry,
  output flags_rf_pkg::flag_t                              ret_flags
);

  import flags_rf_pkg::*;

  localparam int ROW_W = ADDR_W - TILE_BITS;
  localparam int TILES = 2 ** TILE_BITS;
  localparam int ROWS  = 2 ** ROW_W;

  logic [NUM_WR-1:0][ROW_W-1:0] wr_row;

  entry_t tile_rd_entry  [TILES];
  flag_t  tile_ret_flags [TILES];

  logic [TILE_BITS-1:0] rd_sel_q;
  logic [TILE_BITS-1:0] ret_sel_q;

  // Row part is the same for every tile
  always_comb
  begin
    for (int i = 0; i < NUM_WR; i++)
    begin
      wr_row[i] = wr_addr[i][ADDR_W-1:TILE_BITS];
    end
  end

  for (genvar t = 0; t < TILES; t++)
  begin : g_tile
    logic [NUM_WR-1:0] tile_wr_en;
    logic              tile_alloc_en;

    always_comb
    begin
      for (int i = 0; i < NUM_WR; i++)
      begin
        tile_wr_en[i] = wr_en[i] && (wr_addr[i][TILE_BITS-1:0] == TILE_BITS'(t));
      end
    end

    assign tile_alloc_en = alloc_en && (alloc_addr[TILE_BITS-1:0] == TILE_BITS'(t));

    flags_tile #(
      .ROWS (ROWS)
    ) u_tile (
      .clk       (clk),
      .rst       (rst),
      .wr_en     (tile_wr_en),
      .wr_row    (wr_row),
      .wr_flags  (wr_flags),
      .alloc_en  (tile_alloc_en),
      .alloc_row (alloc_addr[ADDR_W-1:TILE_BITS]),
      .clr_en    (clr_en),
      .clr_row   (clr_row),
      .rd_row    (rd_addr[ADDR_W-1:TILE_BITS]),
      .ret_row   (ret_addr[ADDR_W-1:TILE_BITS]),
      .rd_entry  (tile_rd_entry[t]),
      .ret_flags (tile_ret_flags[t])
    );
  end

  // Tile selects follow the tiles' own address registers
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_sel_q  <= '0;
      ret_sel_q <= '0;
    end
    else
    begin
      rd_sel_q  <= rd_addr[TILE_BITS-1:0];
      ret_sel_q <= ret_addr[TILE_BITS-1:0];
    end
  end

  assign rd_entry  = tile_rd_entry[rd_sel_q];
  assign ret_flags = tile_ret_flags[ret_sel_q];

endmodule

// ==== src/flags_tile.sv ====
// One storage tile with result writes, allocate, clear, speculative and retire reads
`timescale 1ns/1ps

module flags_tile #(
  parameter int ROWS = 16
) (
  input  logic                                                  clk,
  input  logic                                                  rst,
  input  logic [flags_rf_pkg::NUM_WR-1:0]                       wr_en,
  input  logic [flags_rf_pkg::NUM_WR-1:0][$clog2(ROWS)-1:0]     wr_row,
  input  flags_rf_pkg::flag_t [flags_rf_pkg::NUM_WR-1:0]        wr_flags,
  input  logic                                                  alloc_en,
  input  logic [$clog2(ROWS)-1:0]                               alloc_row,
  input  logic                                                  clr_en,
  input  logic [$clog2(ROWS)-1:0]                               clr_row,
  input  logic [$clog2(ROWS)-1:0]                               rd_row,
  input  logic [$clog2(ROWS)-1:0]                               ret_row,
  output flags_rf_pkg::entry_t                                  rd_entry,
  output flags_rf_pkg::flag_t                                   ret_flags
);

  import flags_rf_pkg::*;

  localparam int ROW_W = $clog2(ROWS);

  entry_t mem [ROWS];

  logic [ROW_W-1:0] rd_row_q;
  logic [ROW_W-1:0] ret_row_q;

  // Later assignments win, so the allocate has the last word
  always_ff @(posedge clk)
  begin
    if (clr_en)
    begin
      mem[clr_row] <= '0;
    end
    for (int i = 0; i < NUM_WR; i++)
    begin
      if (wr_en[i])
      begin
        mem[wr_row[i]] <= '{pending: 1'b0, flags: wr_flags[i]};
      end
    end
    if (alloc_en)
    begin
      mem[alloc_row] <= PENDING_ENTRY;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rd_row_q  <= '0;
      ret_row_q <= '0;
    end
    else
    begin
      rd_row_q  <= rd_row;
      ret_row_q <= ret_row;
    end
  end

  // Read after the edge, so a write on the capture edge is seen
  assign rd_entry  = mem[rd_row_q];
  assign ret_flags = mem[ret_row_q].flags;

endmodule

// ==== src/flags_rf_pkg.sv ====
// Shared widths, flags and entry types, pending value and clear sequencer state
package flags_rf_pkg;

  // Entry address width for 64 renamed registers
  localparam int ADDR_W = 6;

  // Low address bits that pick the tile
  localparam int TILE_BITS = 2;

  localparam int FLAG_W = 6;

  // Result write ports besides the allocate port
  localparam int NUM_WR = 3;

  typedef logic [FLAG_W-1:0] flag_t;

  // Pending bit sits above the flags
  typedef struct packed {
    logic  pending;
    flag_t flags;
  } entry_t;

  // Written by the allocate port
  localparam entry_t PENDING_ENTRY = '{pending: 1'b1, flags: '1};

  typedef enum logic {
    CLEAR_RUN,  // Zeroing one row per cycle
    CLEAR_IDLE
  } clear_state_e;

endpackage
